// File: src/uart_frame_pkg.sv
`default_nettype none

package uart_frame_pkg;

	localparam int OVERSAMPLE = 16;                     // ticks per bit
	localparam int OS_BITS = $clog2(OVERSAMPLE);
	localparam int FIFO_ADDR_BITS = 2;
	localparam int FIFO_DEPTH = 1 << FIFO_ADDR_BITS;
	localparam int DIV_BITS = 16;

	typedef enum logic [1:0]
	{
		PAR_NONE = 2'd0,
		PAR_EVEN = 2'd1,
		PAR_ODD  = 2'd2
	} parity_e;

	typedef struct packed
	{
		logic                data8;                     // 0 = seven data bits
		parity_e             parity;
		logic                stop2;
		logic [DIV_BITS-1:0] divisor;                   // tick every divisor+1 clocks
	} uart_cfg_t;

	typedef struct packed
	{
		logic parity;
		logic frame;
		logic rx_overflow;
		logic tx_overflow;
	} uart_err_t;

	// 8N1 at the fastest tick
	localparam uart_cfg_t CFG_RESET = '{
		data8:   1'b1,
		parity:  PAR_NONE,
		stop2:   1'b0,
		divisor: '0
	};

endpackage

`default_nettype wire

// File: src/uart_bus_pkg.sv
`default_nettype none

package uart_bus_pkg;

	localparam int NUM_CH = 2;

	typedef enum logic [1:0]
	{
		REG_DATA   = 2'd0,
		REG_STATUS = 2'd1,
		REG_CONFIG = 2'd2
	} reg_e;

	typedef struct packed
	{
		logic        cyc;
		logic        stb;
		logic        we;
		logic [2:0]  adr;                               // channel bit over reg_e
		logic [31:0] dat_w;
	} wb_req_t;

	typedef struct packed
	{
		logic        access;                            // one cycle per bus access
		logic        we;
		reg_e        reg_sel;
		logic [31:0] dat_w;
	} ch_req_t;

endpackage

`default_nettype wire

// File: src/uart_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module uart_fifo
(
	input wire         clk,
	input wire         reset,
	input wire         wr,
	input wire         rd,
	input wire  [7:0]  w_data,
	output logic [7:0] r_data,
	output logic       empty,
	output logic       full
);
	import uart_frame_pkg::*;

	logic [7:0] mem [FIFO_DEPTH];
	logic [FIFO_ADDR_BITS:0] w_ptr;                     // extra msb tells full from empty
	logic [FIFO_ADDR_BITS:0] r_ptr;
	logic wr_en;
	logic rd_en;

	assign empty = (w_ptr == r_ptr);
	assign full = (w_ptr[FIFO_ADDR_BITS] != r_ptr[FIFO_ADDR_BITS]) &&
		(w_ptr[FIFO_ADDR_BITS-1:0] == r_ptr[FIFO_ADDR_BITS-1:0]);
	assign wr_en = wr && !full;
	assign rd_en = rd && !empty;
	assign r_data = mem[r_ptr[FIFO_ADDR_BITS-1:0]];     // head is visible before the read

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[w_ptr[FIFO_ADDR_BITS-1:0]] <= w_data;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			w_ptr <= '0;
			r_ptr <= '0;
		end
		else
		begin
			if (wr_en)
				w_ptr <= w_ptr + 1'b1;
			if (rd_en)
				r_ptr <= r_ptr + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: src/uart_rx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_rx
(
	input wire                       clk,
	input wire                       reset,
	input wire uart_frame_pkg::uart_cfg_t cfg,
	input wire                       s_tick,
	input wire                       rx,
	output logic                     done,
	output logic [7:0]               dout,
	output logic                     parity_err,
	output logic                     frame_err
);
	import uart_frame_pkg::*;

	typedef enum logic [2:0] {IDLE, START, DATA, PARITY, STOP} state_e;

	state_e state;
	logic [1:0] rx_sync;
	logic rx_s;
	logic [OS_BITS-1:0] s_cnt;                          // wraps once per bit
	logic [2:0] n_cnt;
	logic [2:0] last_bit;
	logic par_acc;
	logic bit_mid;

	assign rx_s = rx_sync[1];
	assign last_bit = cfg.data8 ? 3'd7 : 3'd6;
	assign bit_mid = s_tick && (s_cnt == OS_BITS'(OVERSAMPLE - 1));

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			rx_sync <= 2'b11;                           // line idles high
		else
			rx_sync <= {rx_sync[0], rx};
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= IDLE;
			s_cnt <= '0;
			n_cnt <= '0;
			par_acc <= 1'b0;
			done <= 1'b0;
			dout <= '0;
			parity_err <= 1'b0;
			frame_err <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (s_tick)
				s_cnt <= s_cnt + 1'b1;
			case (state)
				IDLE:
					if (!rx_s)
					begin
						state <= START;
						s_cnt <= '0;
					end
				START:
					if (s_tick && s_cnt == OS_BITS'(OVERSAMPLE / 2 - 1))
					begin
						s_cnt <= '0;                    // from here bit_mid hits mid-bit
						n_cnt <= '0;
						par_acc <= 1'b0;
						parity_err <= 1'b0;
						dout <= '0;
						state <= rx_s ? IDLE : DATA;    // line back high means a glitch
					end
				DATA:
					if (bit_mid)
					begin
						dout[n_cnt] <= rx_s;            // lsb first
						par_acc <= par_acc ^ rx_s;
						n_cnt <= n_cnt + 1'b1;
						if (n_cnt == last_bit)
							state <= (cfg.parity == PAR_NONE) ? STOP : PARITY;
					end
				PARITY:
					if (bit_mid)
					begin
						parity_err <= (par_acc ^ rx_s) != (cfg.parity == PAR_ODD);
						state <= STOP;
					end
				STOP:
					if (bit_mid)
					begin
						frame_err <= !rx_s;             // second stop bit is not checked
						done <= 1'b1;
						state <= IDLE;
					end
				default:
					state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/uart_tx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tx
(
	input wire                       clk,
	input wire                       reset,
	input wire uart_frame_pkg::uart_cfg_t cfg,
	input wire                       s_tick,
	input wire                       start,
	input wire [7:0]                 din,
	output logic                     done,
	output logic                     tx
);
	import uart_frame_pkg::*;

	typedef enum logic [2:0] {IDLE, START, DATA, PARITY, STOP} state_e;

	state_e state;
	logic [OS_BITS-1:0] s_cnt;
	logic [2:0] n_cnt;                                  // data bit index, then stop bit index
	logic [2:0] last_bit;
	logic [7:0] din_m;
	logic [7:0] shreg;
	logic par_bit;
	logic bit_end;

	assign last_bit = cfg.data8 ? 3'd7 : 3'd6;
	assign din_m = cfg.data8 ? din : {1'b0, din[6:0]};  // bit 7 dropped in 7-bit mode
	assign bit_end = s_tick && (s_cnt == OS_BITS'(OVERSAMPLE - 1));
	assign done = (state == STOP) && bit_end && (n_cnt[0] || !cfg.stop2);

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= IDLE;
			s_cnt <= '0;
			n_cnt <= '0;
			shreg <= '0;
			par_bit <= 1'b0;
			tx <= 1'b1;
		end
		else
		begin
			if (s_tick)
				s_cnt <= s_cnt + 1'b1;
			case (state)
				IDLE:
				begin
					tx <= 1'b1;
					if (start)
					begin
						state <= START;
						s_cnt <= '0;
						tx <= 1'b0;
						shreg <= din_m;
						par_bit <= (^din_m) ^ (cfg.parity == PAR_ODD);
					end
				end
				START:
					if (bit_end)
					begin
						state <= DATA;
						n_cnt <= '0;
						tx <= shreg[0];
					end
				DATA:
					if (bit_end)
					begin
						shreg <= shreg >> 1;
						n_cnt <= n_cnt + 1'b1;
						if (n_cnt != last_bit)
							tx <= shreg[1];
						else if (cfg.parity == PAR_NONE)
						begin
							state <= STOP;
							n_cnt <= '0;
							tx <= 1'b1;
						end
						else
						begin
							state <= PARITY;
							tx <= par_bit;
						end
					end
				PARITY:
					if (bit_end)
					begin
						state <= STOP;
						n_cnt <= '0;
						tx <= 1'b1;
					end
				STOP:
					if (bit_end)
					begin
						n_cnt <= n_cnt + 1'b1;
						if (done)
							state <= IDLE;
					end
				default:
					state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/uart_channel.sv
`timescale 1ns/100ps
`default_nettype none

module uart_channel
(
	input wire                    clk,
	input wire                    reset,
	input wire uart_bus_pkg::ch_req_t req,
	input wire                    rx,
	output logic                  tx,
	output logic [31:0]           rd_word,
	output logic                  rx_ready
);
	import uart_frame_pkg::*;
	import uart_bus_pkg::*;

	uart_cfg_t cfg;
	uart_err_t err;
	logic [DIV_BITS-1:0] baud_cnt;
	logic s_tick;
	logic data_wr;
	logic data_rd;
	logic status_wr;
	logic config_wr;
	logic tx_full;
	logic tx_empty;
	logic tx_done;
	logic [7:0] tx_head;
	logic rx_full;
	logic rx_empty;
	logic rx_done;
	logic rx_parity_err;
	logic rx_frame_err;
	logic [7:0] rx_byte;
	logic [7:0] rx_head;

	assign data_wr = req.access && req.we && (req.reg_sel == REG_DATA);
	assign data_rd = req.access && !req.we && (req.reg_sel == REG_DATA);
	assign status_wr = req.access && req.we && (req.reg_sel == REG_STATUS);
	assign config_wr = req.access && req.we && (req.reg_sel == REG_CONFIG);
	assign s_tick = (baud_cnt >= cfg.divisor);          // also catches a divisor lowered mid-count
	assign rx_ready = !rx_empty;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			baud_cnt <= '0;
			cfg <= CFG_RESET;
			err <= '0;
		end
		else
		begin
			baud_cnt <= s_tick ? '0 : baud_cnt + 1'b1;
			if (config_wr)
				cfg <= req.dat_w[$bits(uart_cfg_t)-1:0];
			if (status_wr)
				err <= err & ~req.dat_w[2 +: $bits(uart_err_t)];   // write 1 to clear
			if (rx_done && rx_parity_err)
				err.parity <= 1'b1;
			if (rx_done && rx_frame_err)
				err.frame <= 1'b1;
			if (rx_done && rx_full)
				err.rx_overflow <= 1'b1;                // byte is lost
			if (data_wr && tx_full)
				err.tx_overflow <= 1'b1;
		end
	end

	always_comb
	begin
		case (req.reg_sel)
			REG_DATA:   rd_word = rx_empty ? '0 : {24'd0, rx_head};
			REG_STATUS: rd_word = {26'd0, err, !tx_full, !rx_empty};
			REG_CONFIG: rd_word = {12'd0, cfg};
			default:    rd_word = '0;
		endcase
	end

	uart_fifo rx_fifo (.clk, .reset, .wr(rx_done), .rd(data_rd), .w_data(rx_byte),
		.r_data(rx_head), .empty(rx_empty), .full(rx_full));

	uart_fifo tx_fifo (.clk, .reset, .wr(data_wr), .rd(tx_done), .w_data(req.dat_w[7:0]),
		.r_data(tx_head), .empty(tx_empty), .full(tx_full));

	uart_rx rx_unit (.clk, .reset, .cfg, .s_tick, .rx, .done(rx_done), .dout(rx_byte),
		.parity_err(rx_parity_err), .frame_err(rx_frame_err));

	uart_tx tx_unit (.clk, .reset, .cfg, .s_tick, .start(!tx_empty), .din(tx_head),
		.done(tx_done), .tx);

endmodule

`default_nettype wire

// File: src/uart_bus_decode.sv
`timescale 1ns/100ps
`default_nettype none

module uart_bus_decode
(
	input wire                    clk,
	input wire                    reset,
	input wire uart_bus_pkg::wb_req_t wb,
	output logic                  ack,
	output uart_bus_pkg::ch_req_t [uart_bus_pkg::NUM_CH-1:0] ch_req,
	output logic [0:0]            ch_sel
);
	import uart_bus_pkg::*;

	logic accept;

	// ack in flight blocks a second accept while stb is still up
	assign accept = wb.cyc && wb.stb && !ack;
	assign ch_sel = wb.adr[2];

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			ack <= 1'b0;
		else
			ack <= accept;
	end

	always_comb
	begin
		for (int i = 0; i < NUM_CH; i++)
		begin
			ch_req[i].access = accept && (int'(ch_sel) == i);   // addressed channel only
			ch_req[i].we = wb.we;
			ch_req[i].reg_sel = reg_e'(wb.adr[1:0]);
			ch_req[i].dat_w = wb.dat_w;
		end
	end

endmodule

`default_nettype wire

// File: src/uart_read_merge.sv
`timescale 1ns/100ps
`default_nettype none

module uart_read_merge
(
	input wire                                   clk,
	input wire                                   reset,
	input wire                                   access,
	input wire [0:0]                             ch_sel,
	input wire [uart_bus_pkg::NUM_CH-1:0][31:0]  rd_words,
	input wire [uart_bus_pkg::NUM_CH-1:0]        rx_ready,
	output logic [31:0]                          dat_r,
	output logic                                 irq
);

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			dat_r <= '0;
			irq <= 1'b0;
		end
		else
		begin
			if (access)
				dat_r <= rd_words[ch_sel];              // lands on the bus with ack
			irq <= |rx_ready;
		end
	end

endmodule

`default_nettype wire

// File: src/uart_bank.sv
`timescale 1ns/100ps
`default_nettype none

module uart_bank
(
	input wire                              clk,
	input wire                              reset,
	input wire uart_bus_pkg::wb_req_t       wb,
	output logic                            ack,
	output logic [31:0]                     dat_r,
	input wire [uart_bus_pkg::NUM_CH-1:0]   rx,
	output wire [uart_bus_pkg::NUM_CH-1:0]  tx,
	output logic                            irq
);
	import uart_bus_pkg::*;

	ch_req_t [NUM_CH-1:0] ch_req;
	logic [0:0] ch_sel;
	wire [NUM_CH-1:0] ch_access;
	wire [NUM_CH-1:0][31:0] rd_words;
	wire [NUM_CH-1:0] rx_ready;

	uart_bus_decode decode (.clk, .reset, .wb, .ack, .ch_req, .ch_sel);

	for (genvar i = 0; i < NUM_CH; i++)
	begin : g_ch
		assign ch_access[i] = ch_req[i].access;

		uart_channel channel (
			.clk,
			.reset,
			.req(ch_req[i]),
			.rx(rx[i]),
			.tx(tx[i]),
			.rd_word(rd_words[i]),
			.rx_ready(rx_ready[i])
		);
	end

	uart_read_merge merge (
		.clk,
		.reset,
		.access(|ch_access),
		.ch_sel,
		.rd_words,
		.rx_ready,
		.dat_r,
		.irq
	);

endmodule

`default_nettype wire

// File: verification/uart_bus_tasks.svh
`ifndef UART_BUS_TASKS_SVH
`define UART_BUS_TASKS_SVH

// wishbone classic master driving its inputs on the falling edge

task automatic finish_access();
	int waits;
	waits = 0;
	do
	begin
		@(negedge clk);
		waits++;
	end
	while (!ack);
	wb.cyc = 1'b0;                                      // drop the cycle right after ack
	wb.stb = 1'b0;
	wb.we = 1'b0;
	check_val("clocks from access to ack", 32'd1, waits);
endtask

task automatic bus_write(input int ch, input reg_e sel, input logic [31:0] data);
	@(negedge clk);
	wb.cyc = 1'b1;
	wb.stb = 1'b1;
	wb.we = 1'b1;
	wb.adr = {ch[0], sel};                              // channel bit over register
	wb.dat_w = data;
	finish_access();
endtask

task automatic bus_read(input int ch, input reg_e sel, output logic [31:0] data);
	@(negedge clk);
	wb.cyc = 1'b1;
	wb.stb = 1'b1;
	wb.we = 1'b0;
	wb.adr = {ch[0], sel};
	wb.dat_w = '0;
	finish_access();
	data = dat_r;                                       // valid together with ack
endtask

// keeps reading STATUS until every bit of mask is set
task automatic wait_status(input int ch, input logic [31:0] mask);
	logic [31:0] st;
	st = '0;
	while ((st & mask) != mask)
		bus_read(ch, REG_STATUS, st);
endtask

`endif

// File: verification/uart_bank_tb.sv
`timescale 1ns/100ps
`default_nettype none

module uart_bank_tb;
	import uart_frame_pkg::*;
	import uart_bus_pkg::*;

	localparam int DIVISOR = 1;
	localparam int FRAMES = 19;                         // 4 + 4 + 1 + 5 + 4 + 1 frames on the wire
	localparam int CYCLE_LIMIT = FRAMES * 11 * OVERSAMPLE * (DIVISOR + 1) * 2;

	// STATUS bits
	localparam logic [31:0] ST_RX_READY = 32'h01;
	localparam logic [31:0] ST_TX_READY = 32'h02;
	localparam logic [31:0] ST_TX_OVF = 32'h04;
	localparam logic [31:0] ST_RX_OVF = 32'h08;
	localparam logic [31:0] ST_FRAME = 32'h10;
	localparam logic [31:0] ST_PARITY = 32'h20;
	localparam logic [31:0] ST_ALL_ERR = 32'h3c;

	logic clk;
	logic reset;
	wb_req_t wb;
	wire ack;
	wire [31:0] dat_r;
	wire [NUM_CH-1:0] rx;
	wire [NUM_CH-1:0] tx;
	wire irq;
	logic rx0_low;                                      // breaks the line into channel 0

	int seed = 47728;
	int cycles = 0;
	int errors = 0;
	int start_errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	string cur_test = "";
	logic [31:0] exp_q [$];
	logic [31:0] act_q [$];
	event data_seen;

	assign rx[0] = rx0_low ? 1'b0 : tx[1];              // crossed loopback
	assign rx[1] = tx[0];

	uart_bank uut (
		.clk,
		.reset,
		.wb,
		.ack,
		.dat_r,
		.rx,
		.tx,
		.irq
	);

	`include "uart_bus_tasks.svh"

	// received byte as the frame format delivers it
	function automatic logic [7:0] expected_rx(input logic [7:0] b, input logic data8);
		return data8 ? b : {1'b0, b[6:0]};
	endfunction

	function automatic logic [31:0] cfg_word(input logic data8, input parity_e par,
		input logic stop2, input logic [15:0] div);
		return {12'd0, data8, par, stop2, div};
	endfunction

	task automatic check_val(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("[FAIL] %s: %s expected %h actual %h", cur_test, what, expected, actual);
			errors++;
		end
	endtask

	task automatic check_reg(input int ch, input reg_e sel, input logic [31:0] expected,
		input string what);
		logic [31:0] word;
		bus_read(ch, sel, word);
		check_val($sformatf("ch%0d %s", ch, what), expected, word);
	endtask

	task automatic read_data(input int ch);
		logic [31:0] word;
		bus_read(ch, REG_DATA, word);
		act_q.push_back(word);
		-> data_seen;
	endtask

	// only the first keep bytes are expected at the far end
	task automatic send_random(input int ch, input int count, input int keep, input logic data8);
		logic [7:0] b;
		for (int k = 0; k < count; k++)
		begin
			b = 8'($random(seed));
			bus_write(ch, REG_DATA, {24'd0, b});
			if (k < keep)
				exp_q.push_back({24'd0, expected_rx(b, data8)});
		end
	endtask

	task automatic receive(input int ch, input int count);
		repeat (count)
		begin
			wait_status(ch, ST_RX_READY);
			check_val("irq while rx_ready", 32'd1, {31'd0, irq});
			read_data(ch);
		end
	endtask

	task automatic set_both(input logic [31:0] cfg);
		bus_write(0, REG_CONFIG, cfg);
		bus_write(1, REG_CONFIG, cfg);
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		start_errors = errors;
	endtask

	task automatic end_test();
		assert (exp_q.size() == 0)
		else
		begin
			$display("error in %s: %0d expected bytes were never read", cur_test, exp_q.size());
			errors++;
			exp_q.delete();
		end
		if (errors == start_errors)
		begin
			tests_passed++;
			$display("test %-16s ok", cur_test);
		end
		else
		begin
			tests_failed++;
			$display("test %-16s failed with %0d errors", cur_test, errors - start_errors);
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout: run still busy after %0d cycles", CYCLE_LIMIT);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// each DATA read against the next expected byte
	initial
	begin
		logic [31:0] actual;
		forever
		begin
			@(data_seen);
			while (act_q.size() > 0)
			begin
				actual = act_q.pop_front();
				assert (exp_q.size() > 0)
				else
				begin
					$display("error in %s: DATA read %h with no byte expected", cur_test, actual);
					errors++;
				end
				if (exp_q.size() > 0)
					check_val("DATA read", exp_q.pop_front(), actual);
			end
		end
	end

	initial
	begin
		reset = 1'b1;
		wb = '0;
		rx0_low = 1'b0;
		repeat (4) @(negedge clk);
		reset = 1'b0;

		begin_test("registers");
		check_val("ack after reset", 32'd0, {31'd0, ack});
		check_val("irq after reset", 32'd0, {31'd0, irq});
		check_val("tx idle after reset", 32'({NUM_CH{1'b1}}), 32'(tx));
		for (int ch = 0; ch < NUM_CH; ch++)
		begin
			check_reg(ch, REG_STATUS, ST_TX_READY, "status after reset");
			check_reg(ch, REG_CONFIG, cfg_word(1'b1, PAR_NONE, 1'b0, 16'd0), "config after reset");
		end
		bus_write(0, REG_CONFIG, cfg_word(1'b1, PAR_ODD, 1'b1, 16'h1234));
		check_reg(0, REG_CONFIG, cfg_word(1'b1, PAR_ODD, 1'b1, 16'h1234), "config readback");
		check_reg(1, REG_CONFIG, cfg_word(1'b1, PAR_NONE, 1'b0, 16'd0), "config untouched");
		bus_write(1, REG_CONFIG, cfg_word(1'b0, PAR_EVEN, 1'b0, 16'h00a5));
		check_reg(1, REG_CONFIG, cfg_word(1'b0, PAR_EVEN, 1'b0, 16'h00a5), "config readback");
		check_reg(0, REG_CONFIG, cfg_word(1'b1, PAR_ODD, 1'b1, 16'h1234), "config untouched");
		end_test();

		begin_test("loopback_8n1");
		set_both(cfg_word(1'b1, PAR_NONE, 1'b0, 16'(DIVISOR)));
		check_val("irq before any byte", 32'd0, {31'd0, irq});
		send_random(0, 4, 4, 1'b1);
		receive(1, 4);
		check_reg(1, REG_STATUS, ST_TX_READY, "status after drain");
		check_val("irq after drain", 32'd0, {31'd0, irq});
		end_test();

		begin_test("format_7e2");
		set_both(cfg_word(1'b0, PAR_EVEN, 1'b1, 16'(DIVISOR)));
		send_random(1, 4, 4, 1'b0);
		receive(0, 4);
		check_reg(0, REG_STATUS, ST_TX_READY, "status after 7E2");
		check_reg(1, REG_STATUS, ST_TX_READY, "status after 7E2");
		end_test();

		begin_test("parity_error");
		bus_write(1, REG_CONFIG, cfg_word(1'b1, PAR_ODD, 1'b0, 16'(DIVISOR)));
		bus_write(0, REG_CONFIG, cfg_word(1'b1, PAR_EVEN, 1'b0, 16'(DIVISOR)));
		send_random(1, 1, 1, 1'b1);
		wait_status(0, ST_RX_READY);
		check_reg(0, REG_STATUS, ST_RX_READY | ST_TX_READY | ST_PARITY, "status with parity");
		receive(0, 1);
		bus_write(0, REG_STATUS, ST_PARITY);                // write 1 to clear
		check_reg(0, REG_STATUS, ST_TX_READY, "status after clear");
		set_both(cfg_word(1'b1, PAR_NONE, 1'b0, 16'(DIVISOR)));
		end_test();

		begin_test("overflow_frame");
		// rx overflow on channel 1 loses the fifth byte
		send_random(0, FIFO_DEPTH, FIFO_DEPTH, 1'b1);
		wait_status(0, ST_TX_READY);
		send_random(0, 1, 0, 1'b1);
		wait_status(1, ST_RX_OVF);
		check_reg(1, REG_STATUS, ST_RX_READY | ST_TX_READY | ST_RX_OVF, "status on rx overflow");
		receive(1, FIFO_DEPTH);
		bus_write(1, REG_STATUS, ST_ALL_ERR);
		check_reg(1, REG_STATUS, ST_TX_READY, "status after clear");
		// tx overflow on channel 1 drops the last two writes
		send_random(1, FIFO_DEPTH + 2, FIFO_DEPTH, 1'b1);
		check_reg(1, REG_STATUS, ST_TX_OVF, "status on tx overflow");
		receive(0, FIFO_DEPTH);
		bus_write(1, REG_STATUS, ST_ALL_ERR);
		check_reg(1, REG_STATUS, ST_TX_READY, "status after clear");
		check_reg(0, REG_STATUS, ST_TX_READY, "receiver status");
		// line into channel 0 held low gives an all zero frame with a bad stop bit
		@(negedge clk);
		rx0_low = 1'b1;
		wait_status(0, ST_FRAME);
		rx0_low = 1'b0;
		exp_q.push_back(32'd0);
		check_reg(0, REG_STATUS, ST_RX_READY | ST_TX_READY | ST_FRAME, "status on frame error");
		read_data(0);
		bus_write(0, REG_STATUS, ST_ALL_ERR);
		check_reg(0, REG_STATUS, ST_TX_READY, "status after clear");
		end_test();

		begin_test("empty_read");
		for (int ch = 0; ch < NUM_CH; ch++)
		begin
			check_reg(ch, REG_STATUS, ST_TX_READY, "status before empty read");
			exp_q.push_back(32'd0);
			read_data(ch);
			check_reg(ch, REG_STATUS, ST_TX_READY, "status after empty read");
		end
		end_test();

		$display("%0d tests passed, %0d tests failed, %0d checks failed",
			tests_passed, tests_failed, errors);
		if (tests_failed == 0 && errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
+incdir+verification
src/uart_frame_pkg.sv
src/uart_bus_pkg.sv
src/uart_fifo.sv
src/uart_rx.sv
src/uart_tx.sv
src/uart_channel.sv
src/uart_bus_decode.sv
src/uart_read_merge.sv
src/uart_bank.sv
verification/uart_bank_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := uart_bank_tb
FILELIST := all.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard verification/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "ALL TESTS PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
